// ==== src/laser_pkg.sv ====
`default_nettype none

package laser_pkg;

    // Start bit, eight data bits, stop bit
    localparam int FRAME_BITS = 10;

    // Start sits in bit 0 so the frame goes out LSB first
    typedef struct packed {
        logic       stop;
        logic [7:0] data;
        logic       start;
    } frame_fields_t;

    // Shifted as raw bits on the line, built and read back as fields
    typedef union packed {
        logic [FRAME_BITS-1:0] raw;
        frame_fields_t         fields;
    } frame_word_u;

    // Two-bit drive of one laser, light above enable
    typedef struct packed {
        logic light;
        logic enable;
    } lane_drive_t;

    typedef struct packed {
        lane_drive_t lane1;
        lane_drive_t lane2;
    } laser_drive_t;

endpackage

`default_nettype wire

// ==== src/link_pkg.sv ====
`default_nettype none

package link_pkg;

    // One transfer unit, one byte per lane
    typedef struct packed {
        logic [7:0] lane2_byte;
        logic [7:0] lane1_byte;
    } byte_pair_t;

    // Received frame words of both lanes, filled by the samplers
    typedef struct packed {
        laser_pkg::frame_word_u lane1;
        laser_pkg::frame_word_u lane2;
    } lane_frames_t;

endpackage

`default_nettype wire

// ==== src/bit_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module bit_timer #(
    parameter int CYCLES_PER_BIT = 8
) (
    input  logic clock,
    input  logic reset,
    input  logic run,
    output logic tick,
    output logic vote_window
);

    localparam int COUNT_W = $clog2(CYCLES_PER_BIT);
    localparam int MID     = CYCLES_PER_BIT / 2;

    logic [COUNT_W-1:0] count;

    // Free count within one bit period, parked at zero while idle
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (!run || count == COUNT_W'(CYCLES_PER_BIT - 1)) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Last cycle of the bit period
    assign tick = run && (count == COUNT_W'(CYCLES_PER_BIT - 1));

    // Three samples around mid-bit
    assign vote_window = run && (count >= COUNT_W'(MID - 1)) && (count <= COUNT_W'(MID + 1));

    a_tick_outside_window: assert property (
        @(posedge clock) disable iff (reset) !(tick && vote_window)
    ) else $error("bit_timer: tick inside the vote window");

endmodule

`default_nettype wire

// ==== src/tx_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_sequencer (
    input  logic clock,
    input  logic reset,
    input  logic enable,
    input  logic tx_strobe,
    input  logic bit_tick,
    output logic timer_run,
    output logic load,
    output logic shift,
    output logic tx_busy,
    output logic tx_done
);

    enum logic {IDLE, SEND} state;

    logic [3:0] bit_count;
    logic       last_bit;

    assign last_bit = (bit_count == 4'(laser_pkg::FRAME_BITS - 1));

    // Strobe only counts when idle and enabled
    assign load      = (state == IDLE) && tx_strobe && enable;
    assign shift     = (state == SEND) && bit_tick;
    assign tx_busy   = (state == SEND);
    assign timer_run = (state == SEND);
    assign tx_done   = (state == SEND) && bit_tick && last_bit && enable;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (load) state <= SEND;
                // Abort on enable low, otherwise stop after the stop bit
                SEND: if (!enable || (bit_tick && last_bit)) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Bits already sent in the current frame
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            bit_count <= '0;
        end else if (state != SEND || !enable) begin
            bit_count <= '0;
        end else if (bit_tick) begin
            bit_count <= bit_count + 1'b1;
        end
    end

    a_no_strobe_when_busy: assert property (
        @(posedge clock) disable iff (reset) tx_busy |-> !tx_strobe
    ) else $error("tx_sequencer: tx_strobe while tx_busy");

endmodule

`default_nettype wire

// ==== src/tx_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_serializer (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    enable,
    input  logic                    load,
    input  logic                    shift,
    input  link_pkg::byte_pair_t    tx_pair,
    input  logic                    sending,
    output laser_pkg::laser_drive_t laser_drive
);

    laser_pkg::frame_word_u frame1;
    laser_pkg::frame_word_u frame2;

    // Built by fields, then shifted out raw from bit 0
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            frame1 <= '0;
            frame2 <= '0;
        end else if (load) begin
            frame1.fields <= '{stop: 1'b0, data: tx_pair.lane1_byte, start: 1'b1};
            frame2.fields <= '{stop: 1'b0, data: tx_pair.lane2_byte, start: 1'b1};
        end else if (shift) begin
            frame1.raw <= frame1.raw >> 1;
            frame2.raw <= frame2.raw >> 1;
        end
    end

    // Line idles at 0 whenever no frame is on the way
    always_comb begin
        laser_drive.lane1.light  = sending && frame1.raw[0];
        laser_drive.lane2.light  = sending && frame2.raw[0];
        laser_drive.lane1.enable = enable;
        laser_drive.lane2.enable = enable;
    end

endmodule

`default_nettype wire

// ==== src/rx_lane_sampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_lane_sampler #(
    parameter int CYCLES_PER_BIT = 8
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   light,
    input  logic                   timer_run,
    input  logic                   vote_window,
    input  logic                   bit_tick,
    output logic                   level,
    output laser_pkg::frame_word_u frame
);

    logic [1:0] sync;
    logic [1:0] vote;

    // Window must stay clear of the bit edges after the two sync cycles
    if (CYCLES_PER_BIT < 6) begin : g_cpb_check
        $error("rx_lane_sampler: CYCLES_PER_BIT must be 6 or more");
    end

    // Two-flop synchronizer on the incoming light
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            sync <= '0;
        end else begin
            sync <= {sync[0], light};
        end
    end

    assign level = sync[1];

    // High samples seen in the vote window
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            vote <= '0;
        end else if (!timer_run || bit_tick) begin
            vote <= '0;
        end else if (vote_window && level) begin
            vote <= vote + 1'b1;
        end
    end

    // Majority bit enters at the top so the oldest bit ends up in bit 0
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            frame <= '0;
        end else if (bit_tick) begin
            frame.raw <= {vote[1], frame.raw[laser_pkg::FRAME_BITS-1:1]};
        end
    end

endmodule

`default_nettype wire

// ==== src/rx_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_sequencer (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   level1,
    input  logic                   level2,
    input  logic                   bit_tick,
    input  link_pkg::lane_frames_t frames,
    output logic                   timer_run,
    output link_pkg::byte_pair_t   rx_pair,
    output logic                   rx_valid
);

    enum logic [1:0] {WAIT, RECEIVE, CHECK} state, next_state;

    logic [3:0] bit_count;
    logic       last_bit;
    logic       start_seen;
    logic       stops_ok;

    assign last_bit   = (bit_count == 4'(laser_pkg::FRAME_BITS - 1));
    assign start_seen = level1 || level2;
    assign stops_ok   = !frames.lane1.fields.stop && !frames.lane2.fields.stop;

    // Timer starts in the same cycle the start edge shows up
    assign timer_run = (state == RECEIVE) || (state == WAIT && start_seen);

    always_comb begin
        next_state = state;
        case (state)
            WAIT:    if (start_seen) next_state = RECEIVE;
            RECEIVE: if (bit_tick && last_bit) next_state = CHECK;
            CHECK:   next_state = WAIT;
            default: next_state = WAIT;
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state <= WAIT;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            bit_count <= '0;
        end else if (state != RECEIVE) begin
            bit_count <= '0;
        end else if (bit_tick) begin
            bit_count <= bit_count + 1'b1;
        end
    end

    // Bad stop on either lane drops the pair without notice
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            rx_valid <= 1'b0;
            rx_pair  <= '0;
        end else begin
            rx_valid <= (state == CHECK) && stops_ok;
            if (state == CHECK && stops_ok) begin
                rx_pair.lane1_byte <= frames.lane1.fields.data;
                rx_pair.lane2_byte <= frames.lane2.fields.data;
            end
        end
    end

    a_valid_single_cycle: assert property (
        @(posedge clock) disable iff (reset) rx_valid |=> !rx_valid
    ) else $error("rx_sequencer: rx_valid held for two cycles");

endmodule

`default_nettype wire

// ==== src/laser_link_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module laser_link_top #(
    parameter int CYCLES_PER_BIT = 8
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    enable,
    input  link_pkg::byte_pair_t    tx_pair,
    input  logic                    tx_strobe,
    output logic                    tx_busy,
    output logic                    tx_done,
    output laser_pkg::laser_drive_t laser_drive,
    input  logic [1:0]              rx_light,
    output link_pkg::byte_pair_t    rx_pair,
    output logic                    rx_valid
);

    logic tx_timer_run;
    logic tx_tick;
    logic tx_load;
    logic tx_shift;

    logic                   rx_timer_run;
    logic                   rx_tick;
    logic                   rx_vote_window;
    logic                   level1;
    logic                   level2;
    link_pkg::lane_frames_t frames;

    // Transmit path
    tx_sequencer tx_sequencer_i (
        .clock, .reset, .enable, .tx_strobe,
        .bit_tick  (tx_tick),
        .timer_run (tx_timer_run),
        .load      (tx_load),
        .shift     (tx_shift),
        .tx_busy, .tx_done
    );

    bit_timer #(.CYCLES_PER_BIT(CYCLES_PER_BIT)) tx_timer_i (
        .clock, .reset,
        .run         (tx_timer_run),
        .tick        (tx_tick),
        .vote_window ()
    );

    tx_serializer tx_serializer_i (
        .clock, .reset, .enable,
        .load    (tx_load),
        .shift   (tx_shift),
        .tx_pair,
        .sending (tx_busy),
        .laser_drive
    );

    // Receive path, lane 1 on bit 0
    rx_lane_sampler #(.CYCLES_PER_BIT(CYCLES_PER_BIT)) rx_lane1_i (
        .clock, .reset,
        .light (rx_light[0]), .timer_run (rx_timer_run),
        .vote_window (rx_vote_window), .bit_tick (rx_tick),
        .level (level1), .frame (frames.lane1)
    );

    rx_lane_sampler #(.CYCLES_PER_BIT(CYCLES_PER_BIT)) rx_lane2_i (
        .clock, .reset,
        .light (rx_light[1]), .timer_run (rx_timer_run),
        .vote_window (rx_vote_window), .bit_tick (rx_tick),
        .level (level2), .frame (frames.lane2)
    );

    bit_timer #(.CYCLES_PER_BIT(CYCLES_PER_BIT)) rx_timer_i (
        .clock, .reset,
        .run         (rx_timer_run),
        .tick        (rx_tick),
        .vote_window (rx_vote_window)
    );

    rx_sequencer rx_sequencer_i (
        .clock, .reset, .level1, .level2,
        .bit_tick  (rx_tick),
        .frames,
        .timer_run (rx_timer_run),
        .rx_pair, .rx_valid
    );

endmodule

`default_nettype wire

// ==== verification/link_vectors.svh ====
`ifndef LINK_VECTORS_SVH
`define LINK_VECTORS_SVH

// Columns: random, enable, glitch, expected rx_valid count, tx_pair, expected rx_pair
// Pairs are written lane 2 byte first, random rows take both from the LFSR

localparam logic [1:0] GLITCH_NONE = 2'd0;
// One inverted vote sample in a lane 2 data bit
localparam logic [1:0] GLITCH_DATA = 2'd1;
// Two inverted vote samples in the lane 1 stop bit
localparam logic [1:0] GLITCH_STOP = 2'd2;

localparam int NUM_VECTORS = 8;

typedef struct packed {
    logic                 random;
    logic                 enable;
    logic [1:0]           glitch;
    logic [1:0]           expect_count;
    link_pkg::byte_pair_t pair;
    link_pkg::byte_pair_t expect_pair;
} vector_t;

function automatic vector_t vector_row(input int index, output string name);
    vector_t row;
    row  = '0;
    name = "unknown";
    case (index)
        0: begin
            name = "fixed_a5_3c";
            row  = '{1'b0, 1'b1, GLITCH_NONE, 2'd1, 16'h3ca5, 16'h3ca5};
        end
        1: begin
            name = "fixed_ff_00";
            row  = '{1'b0, 1'b1, GLITCH_NONE, 2'd1, 16'h00ff, 16'h00ff};
        end
        2: begin
            name = "random_1";
            row  = '{1'b1, 1'b1, GLITCH_NONE, 2'd1, 16'h0000, 16'h0000};
        end
        3: begin
            name = "data_glitch";
            row  = '{1'b0, 1'b1, GLITCH_DATA, 2'd1, 16'h7e81, 16'h7e81};
        end
        4: begin
            name = "stop_glitch";
            row  = '{1'b0, 1'b1, GLITCH_STOP, 2'd0, 16'haa55, 16'h0000};
        end
        5: begin
            name = "after_glitch";
            row  = '{1'b0, 1'b1, GLITCH_NONE, 2'd1, 16'h1234, 16'h1234};
        end
        6: begin
            name = "enable_low";
            row  = '{1'b0, 1'b0, GLITCH_NONE, 2'd0, 16'h6699, 16'h0000};
        end
        7: begin
            name = "random_2";
            row  = '{1'b1, 1'b1, GLITCH_NONE, 2'd1, 16'h0000, 16'h0000};
        end
        default: name = "unknown";
    endcase
    return row;
endfunction

`endif

// ==== verification/laser_link_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module laser_link_tb;

    localparam int CYCLES_PER_BIT = 8;
    localparam int MID            = CYCLES_PER_BIT / 2;
    localparam int FRAME_CYCLES   = laser_pkg::FRAME_BITS * CYCLES_PER_BIT;
    // Room for the synchronizer and stop check after the line goes idle
    localparam int DRAIN_CYCLES   = CYCLES_PER_BIT;

    `include "link_vectors.svh"

    localparam int TIMEOUT_CYCLES = NUM_VECTORS * 12 * CYCLES_PER_BIT + 100;

    logic                    clock;
    logic                    reset;
    logic                    enable;
    link_pkg::byte_pair_t    tx_pair;
    logic                    tx_strobe;
    logic                    tx_busy;
    logic                    tx_done;
    laser_pkg::laser_drive_t laser_drive;
    logic [1:0]              rx_light;
    logic [1:0]              glitch;
    link_pkg::byte_pair_t    rx_pair;
    logic                    rx_valid;

    logic [15:0] lfsr_state;
    string       current_test;
    int          test_errors;
    int          pass_count;
    int          fail_count;
    int          cycle_count;

    laser_link_top #(.CYCLES_PER_BIT(CYCLES_PER_BIT)) laser_link_top_i (
        .clock, .reset, .enable, .tx_pair, .tx_strobe, .tx_busy, .tx_done,
        .laser_drive, .rx_light, .rx_pair, .rx_valid
    );

    // Loopback, lane 1 on bit 0, with chosen samples inverted
    assign rx_light = {laser_drive.lane2.light, laser_drive.lane1.light} ^ glitch;

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hb400;
        end
        return state >> 1;
    endfunction

    // One step per bit, first bit drawn lands in bit 0
    task automatic draw_pair(output link_pkg::byte_pair_t pair);
        repeat (16) begin
            pair = {lfsr_state[0], pair[15:1]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic check_value(input string what, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s %s expected %h actual %h",
                     current_test, what, expected, actual);
            test_errors++;
        end
    endtask

    // Line level of frame bit n: start 1, data LSB first, stop 0
    function automatic logic expected_line(input logic [7:0] data, input int n);
        logic [9:0] word;
        word = {1'b0, data, 1'b1} >> n;
        return word[0];
    endfunction

    // Inverted lanes in frame cycle k, aimed at the mid-bit vote samples
    function automatic logic [1:0] glitch_for(input logic [1:0] code, input int k);
        if (code == GLITCH_DATA && k == 3 * CYCLES_PER_BIT + MID) begin
            return 2'b10;
        end
        if (code == GLITCH_STOP && (k == 9 * CYCLES_PER_BIT + MID - 1 ||
                                    k == 9 * CYCLES_PER_BIT + MID)) begin
            return 2'b01;
        end
        return 2'b00;
    endfunction

    task automatic finish_test();
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s passed", current_test);
        end else begin
            fail_count++;
            $display("test %s failed with %0d errors", current_test, test_errors);
        end
    endtask

    task automatic run_vector(input int index);
        vector_t              row;
        string                name;
        link_pkg::byte_pair_t pair;
        link_pkg::byte_pair_t expect_pair;
        link_pkg::byte_pair_t captured;
        int                   valid_count;
        logic                 light1;
        logic                 light2;

        row          = vector_row(index, name);
        current_test = name;
        test_errors  = 0;
        pair         = row.pair;
        expect_pair  = row.expect_pair;
        if (row.random) begin
            draw_pair(pair);
            expect_pair = pair;
        end
        valid_count = 0;
        captured    = '0;

        enable    = row.enable;
        tx_pair   = pair;
        tx_strobe = 1'b1;
        next_cycle();
        tx_strobe = 1'b0;
        if (row.enable) begin
            while (!tx_busy) begin
                next_cycle();
            end
        end

        // One pass per cycle of the frame, start bit first
        for (int k = 0; k < FRAME_CYCLES; k++) begin
            glitch = glitch_for(row.glitch, k);
            light1 = row.enable && expected_line(pair.lane1_byte, k / CYCLES_PER_BIT);
            light2 = row.enable && expected_line(pair.lane2_byte, k / CYCLES_PER_BIT);
            check_value("lane1 light", 16'(light1), 16'(laser_drive.lane1.light));
            check_value("lane2 light", 16'(light2), 16'(laser_drive.lane2.light));
            check_value("laser enables", 16'({row.enable, row.enable}),
                        16'({laser_drive.lane1.enable, laser_drive.lane2.enable}));
            check_value("tx_busy", 16'(row.enable), 16'(tx_busy));
            check_value("tx_done", 16'(row.enable && k == FRAME_CYCLES - 1), 16'(tx_done));
            if (rx_valid) begin
                valid_count++;
                captured = rx_pair;
            end
            next_cycle();
        end
        glitch = 2'b00;
        check_value("tx_busy after frame", 16'(1'b0), 16'(tx_busy));

        repeat (DRAIN_CYCLES) begin
            if (rx_valid) begin
                valid_count++;
                captured = rx_pair;
            end
            next_cycle();
        end
        check_value("rx_valid count", 16'(row.expect_count), 16'(valid_count));
        if (row.expect_count != 0) begin
            check_value("rx_pair", expect_pair, captured);
        end
        finish_test();
    endtask

    initial begin
        reset        = 1'b1;
        enable       = 1'b1;
        tx_pair      = '0;
        tx_strobe    = 1'b0;
        glitch       = 2'b00;
        lfsr_state   = 16'd81;
        pass_count   = 0;
        fail_count   = 0;
        test_errors  = 0;
        current_test = "reset_values";
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;

        check_value("tx_busy", 16'(1'b0), 16'(tx_busy));
        check_value("tx_done", 16'(1'b0), 16'(tx_done));
        check_value("rx_valid", 16'(1'b0), 16'(rx_valid));
        check_value("lights", 16'(2'b00),
                    16'({laser_drive.lane2.light, laser_drive.lane1.light}));
        check_value("rx_pair", 16'h0000, rx_pair);
        finish_test();

        for (int i = 0; i < NUM_VECTORS; i++) begin
            run_vector(i);
        end

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog sized from the number of table rows
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("run timed out after %0d cycles before all tests finished", cycle_count);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+verification
src/laser_pkg.sv
src/link_pkg.sv
src/bit_timer.sv
src/tx_sequencer.sv
src/tx_serializer.sv
src/rx_lane_sampler.sv
src/rx_sequencer.sv
src/laser_link_top.sv
verification/laser_link_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the laser link testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f files.f \
    --top-module laser_link_tb -o laser_link_sim || exit 1
output=$(./obj_dir/laser_link_sim)
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qF '** PASS **' && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
